// File: logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BE_W      = 4;               // byte lanes per word
    localparam int BYTE_W    = 8;
    localparam int RAM_IDX_W = 10;              // 1024 words per bank

    // byte offset below the word index
    localparam int WORD_OFS_W = $clog2(BE_W);

    // address map
    localparam logic [ADDR_W-1:0] BASE_RAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] EXT_RAM_BASE  = 32'h8040_0000;
    // 4 MB windows, the small banks alias inside them
    localparam logic [ADDR_W-1:0] RAM_WIN_MASK  = 32'hffc0_0000;

    localparam logic [ADDR_W-1:0] UART_DATA_ADDR = 32'hbfd0_03f8;
    localparam logic [ADDR_W-1:0] UART_STAT_ADDR = 32'hbfd0_03fc;

    // status word layout
    localparam int STAT_TX_READY_BIT = 0;
    localparam int STAT_RX_AVAIL_BIT = 1;

    // serial timing, short bit time for simulation
    // board value would be 50 MHz / 9600 baud
    localparam int CLKS_PER_BIT = 16;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;

    // start + data + stop
    localparam int FRAME_BITS = BYTE_W + 2;

endpackage

`default_nettype wire

// File: logic/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none

module sram_bank (
    input  wire                          clk_i,
    input  wire [soc_pkg::RAM_IDX_W-1:0] idx_i,
    input  wire [soc_pkg::DATA_W-1:0]    wdata_i,
    input  wire [soc_pkg::BE_W-1:0]      wmask_i,    // active high byte lanes
    input  wire                          we_i,
    output logic [soc_pkg::DATA_W-1:0]   rdata_o
);
    import soc_pkg::*;

    localparam int DEPTH = 1 << RAM_IDX_W;

    logic [DATA_W-1:0] mem_q [DEPTH];

    // byte lanes land at the edge closing the strobe cycle
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wmask_i[b]) begin
                    mem_q[idx_i][b*BYTE_W +: BYTE_W] <= wdata_i[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // async read, same cycle as the index
    assign rdata_o = mem_q[idx_i];

endmodule

`default_nettype wire

// File: logic/mem_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module mem_bridge (
    // fetch side, always requesting
    input  wire [soc_pkg::ADDR_W-1:0]     ifu_addr_i,
    output logic [soc_pkg::DATA_W-1:0]    ifu_rdata_o,
    output logic                          ifu_resp_o,

    // load/store side
    input  wire [soc_pkg::ADDR_W-1:0]     lsu_addr_i,
    input  wire [soc_pkg::DATA_W-1:0]     lsu_wdata_i,
    input  wire [soc_pkg::BE_W-1:0]       lsu_be_n_i,
    input  wire                           lsu_re_i,
    input  wire                           lsu_we_i,
    output logic [soc_pkg::DATA_W-1:0]    lsu_rdata_o,
    output logic                          lsu_resp_o,

    // base ram bank
    output logic [soc_pkg::RAM_IDX_W-1:0] base_idx_o,
    output logic [soc_pkg::DATA_W-1:0]    base_wdata_o,
    output logic [soc_pkg::BE_W-1:0]      base_wmask_o,
    output logic                          base_we_o,
    input  wire [soc_pkg::DATA_W-1:0]     base_rdata_i,

    // ext ram bank
    output logic [soc_pkg::RAM_IDX_W-1:0] ext_idx_o,
    output logic [soc_pkg::DATA_W-1:0]    ext_wdata_o,
    output logic [soc_pkg::BE_W-1:0]      ext_wmask_o,
    output logic                          ext_we_o,
    input  wire [soc_pkg::DATA_W-1:0]     ext_rdata_i,

    // serial register block
    output logic                          uart_rd_data_o,
    output logic                          uart_wr_data_o,
    output logic [soc_pkg::BYTE_W-1:0]    uart_wdata_o,
    input  wire [soc_pkg::BYTE_W-1:0]     uart_rx_byte_i,
    input  wire                           uart_rx_avail_i,
    input  wire                           uart_tx_ready_i
);
    import soc_pkg::*;

    logic                  lsu_acc;        // any strobe this cycle
    logic                  sel_base;
    logic                  sel_ext;
    logic                  sel_udata;
    logic                  sel_ustat;
    logic                  lsu_on_base;    // load/store wins base ram
    logic [RAM_IDX_W-1:0]  lsu_idx;
    logic [RAM_IDX_W-1:0]  ifu_idx;
    logic [DATA_W-1:0]     stat_word;
    logic [DATA_W-1:0]     udata_word;
    logic [BE_W-1:0]       wmask;

    assign lsu_acc = lsu_re_i | lsu_we_i;

    // window decode on the upper bits
    assign sel_base  = (lsu_addr_i & RAM_WIN_MASK) == BASE_RAM_BASE;
    assign sel_ext   = (lsu_addr_i & RAM_WIN_MASK) == EXT_RAM_BASE;
    // serial regs are exact matches
    assign sel_udata = lsu_addr_i == UART_DATA_ADDR;
    assign sel_ustat = lsu_addr_i == UART_STAT_ADDR;

    // word index sits just above the byte offset
    assign lsu_idx = lsu_addr_i[WORD_OFS_W +: RAM_IDX_W];
    assign ifu_idx = ifu_addr_i[WORD_OFS_W +: RAM_IDX_W];

    // base ram arbitration, load/store has priority
    assign lsu_on_base = lsu_acc & sel_base;
    assign base_idx_o  = lsu_on_base ? lsu_idx : ifu_idx;
    assign ifu_rdata_o = base_rdata_i;
    assign ifu_resp_o  = ~lsu_on_base;   // fetch holds its address and retries

    // byte enables come in active low
    assign wmask = ~lsu_be_n_i;

    assign base_wdata_o = lsu_wdata_i;
    assign base_wmask_o = wmask;
    assign base_we_o    = lsu_we_i & sel_base;

    // ext ram only ever sees load/store
    assign ext_idx_o   = lsu_idx;
    assign ext_wdata_o = lsu_wdata_i;
    assign ext_wmask_o = wmask;
    assign ext_we_o    = lsu_we_i & sel_ext;

    // data register strobes, single cycle like the lsu strobes
    assign uart_rd_data_o = lsu_re_i & sel_udata;
    assign uart_wr_data_o = lsu_we_i & sel_udata;
    assign uart_wdata_o   = lsu_wdata_i[BYTE_W-1:0];   // low byte only

    // status word, everything else reads zero
    always_comb begin
        stat_word = '0;
        stat_word[STAT_TX_READY_BIT] = uart_tx_ready_i;
        stat_word[STAT_RX_AVAIL_BIT] = uart_rx_avail_i;
    end

    assign udata_word = {{(DATA_W-BYTE_W){1'b0}}, uart_rx_byte_i};

    // read return mux
    always_comb begin
        lsu_rdata_o = '0;                  // unmapped reads zero
        if (sel_base) begin
            lsu_rdata_o = base_rdata_i;
        end else if (sel_ext) begin
            lsu_rdata_o = ext_rdata_i;
        end else if (sel_udata) begin
            lsu_rdata_o = udata_word;
        end else if (sel_ustat) begin
            lsu_rdata_o = stat_word;
        end
    end

    // every target answers in the strobe cycle
    assign lsu_resp_o = lsu_acc;

endmodule

`default_nettype wire

// File: logic/uart_regs.sv
`timescale 1ns/10ps
`default_nettype none

module uart_regs (
    input  wire                         clk_i,
    input  wire                         rst_i,

    // from the bridge
    input  wire                         rd_data_i,    // load of data reg
    input  wire                         wr_data_i,    // store to data reg
    input  wire [soc_pkg::BYTE_W-1:0]   wdata_i,

    // receiver side
    input  wire [soc_pkg::BYTE_W-1:0]   rx_byte_i,
    input  wire                         rx_valid_i,

    // transmitter side
    input  wire                         tx_busy_i,

    output logic [soc_pkg::BYTE_W-1:0]  rx_byte_o,
    output logic                        rx_avail_o,
    output logic                        tx_ready_o,
    output logic                        tx_start_o,
    output logic [soc_pkg::BYTE_W-1:0]  tx_byte_o
);
    import soc_pkg::*;

    logic [BYTE_W-1:0] rx_buf_q;
    logic              rx_avail_q;

    // one byte receive buffer, a newer byte simply overwrites
    always_ff @(posedge clk_i) begin
        if (rx_valid_i) begin
            rx_buf_q <= rx_byte_i;
        end
    end

    // available flag: set by a new byte, cleared by a data load
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_avail_q <= 1'b0;
        end else if (rx_valid_i) begin
            rx_avail_q <= 1'b1;             // new byte wins over a clear
        end else if (rd_data_i) begin
            rx_avail_q <= 1'b0;
        end
    end

    assign rx_byte_o  = rx_buf_q;
    assign rx_avail_o = rx_avail_q;

    // start only when idle, a store while busy is dropped
    assign tx_start_o = wr_data_i & ~tx_busy_i;
    assign tx_byte_o  = wdata_i;        // tx latches it with the start
    assign tx_ready_o = ~tx_busy_i;

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         rxd_i,
    output logic [soc_pkg::BYTE_W-1:0]  byte_o,
    output logic                        byte_valid_o
);
    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_e;

    rx_state_e                 state_q;
    logic                      rxd_meta_q;
    logic                      rxd_sync_q;
    logic [CLK_CNT_W-1:0]      clk_cnt_q;
    logic [$clog2(BYTE_W)-1:0] bit_cnt_q;
    logic [BYTE_W-1:0]         shift_q;
    logic                      valid_q;

    // two flop sync, idle line is high
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_sync_q <= rxd_meta_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= ST_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;                // single cycle pulse
            case (state_q)
                ST_IDLE: begin
                    clk_cnt_q <= '0;
                    if (!rxd_sync_q) state_q <= ST_START;   // falling edge
                end
                ST_START: begin
                    // recheck at mid bit, filters glitches
                    if (clk_cnt_q == CLK_CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= rxd_sync_q ? ST_IDLE : ST_DATA;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                ST_DATA: begin
                    if (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        clk_cnt_q <= '0;
                        shift_q   <= {rxd_sync_q, shift_q[BYTE_W-1:1]};   // lsb first
                        if (bit_cnt_q == ($clog2(BYTE_W))'(BYTE_W - 1)) begin
                            state_q <= ST_STOP;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                ST_STOP: begin
                    if (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
                        valid_q <= rxd_sync_q;      // bad stop bit drops the frame
                        state_q <= ST_IDLE;
                    end else begin
                        clk_cnt_q <= clk_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign byte_o       = shift_q;
    assign byte_valid_o = valid_q;

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        start_i,
    input  wire [soc_pkg::BYTE_W-1:0]  byte_i,
    output logic                       txd_o,
    output logic                       busy_o
);
    import soc_pkg::*;

    logic                          busy_q;
    logic [CLK_CNT_W-1:0]          clk_cnt_q;
    logic [$clog2(FRAME_BITS)-1:0] bit_cnt_q;
    logic [FRAME_BITS-1:0]         frame_q;     // stop, data, start

    // frame shift register, no reset needed
    always_ff @(posedge clk_i) begin
        if (start_i && !busy_q) begin
            frame_q <= {1'b1, byte_i, 1'b0};
        end else if (busy_q && clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!busy_q) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            if (start_i) busy_q <= 1'b1;    // busy from next cycle on
        end else if (clk_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            // last bit is the stop bit
            if (bit_cnt_q == ($clog2(FRAME_BITS))'(FRAME_BITS - 1)) begin
                busy_q <= 1'b0;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    // line held high when idle
    assign txd_o  = busy_q ? frame_q[0] : 1'b1;
    assign busy_o = busy_q;

endmodule

`default_nettype wire

// File: logic/soc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module soc_mem_top (
    input  wire                         clk_i,
    input  wire                         rst_i,

    // instruction fetch
    input  wire [soc_pkg::ADDR_W-1:0]   ifu_addr_i,
    output logic [soc_pkg::DATA_W-1:0]  ifu_rdata_o,
    output logic                        ifu_resp_o,

    // load/store
    input  wire [soc_pkg::ADDR_W-1:0]   lsu_addr_i,
    input  wire [soc_pkg::DATA_W-1:0]   lsu_wdata_i,
    input  wire [soc_pkg::BE_W-1:0]     lsu_be_n_i,
    input  wire                         lsu_re_i,
    input  wire                         lsu_we_i,
    output logic [soc_pkg::DATA_W-1:0]  lsu_rdata_o,
    output logic                        lsu_resp_o,

    // serial pins
    input  wire                         rxd_i,
    output logic                        txd_o
);
    import soc_pkg::*;

    // bridge <-> banks
    wire [RAM_IDX_W-1:0] base_idx;
    wire [DATA_W-1:0]    base_wdata;
    wire [BE_W-1:0]      base_wmask;
    wire                 base_we;
    wire [DATA_W-1:0]    base_rdata;
    wire [RAM_IDX_W-1:0] ext_idx;
    wire [DATA_W-1:0]    ext_wdata;
    wire [BE_W-1:0]      ext_wmask;
    wire                 ext_we;
    wire [DATA_W-1:0]    ext_rdata;

    // bridge <-> serial regs
    wire                 uart_rd_data;
    wire                 uart_wr_data;
    wire [BYTE_W-1:0]    uart_wdata;
    wire [BYTE_W-1:0]    uart_rx_byte;
    wire                 uart_rx_avail;
    wire                 uart_tx_ready;

    // serial regs <-> rx/tx
    wire                 tx_start;
    wire [BYTE_W-1:0]    tx_byte;
    wire                 tx_busy;
    wire [BYTE_W-1:0]    rx_byte;
    wire                 rx_valid;

    mem_bridge u_bridge (
        .ifu_addr_i      (ifu_addr_i),
        .ifu_rdata_o     (ifu_rdata_o),
        .ifu_resp_o      (ifu_resp_o),
        .lsu_addr_i      (lsu_addr_i),
        .lsu_wdata_i     (lsu_wdata_i),
        .lsu_be_n_i      (lsu_be_n_i),
        .lsu_re_i        (lsu_re_i),
        .lsu_we_i        (lsu_we_i),
        .lsu_rdata_o     (lsu_rdata_o),
        .lsu_resp_o      (lsu_resp_o),
        .base_idx_o      (base_idx),
        .base_wdata_o    (base_wdata),
        .base_wmask_o    (base_wmask),
        .base_we_o       (base_we),
        .base_rdata_i    (base_rdata),
        .ext_idx_o       (ext_idx),
        .ext_wdata_o     (ext_wdata),
        .ext_wmask_o     (ext_wmask),
        .ext_we_o        (ext_we),
        .ext_rdata_i     (ext_rdata),
        .uart_rd_data_o  (uart_rd_data),
        .uart_wr_data_o  (uart_wr_data),
        .uart_wdata_o    (uart_wdata),
        .uart_rx_byte_i  (uart_rx_byte),
        .uart_rx_avail_i (uart_rx_avail),
        .uart_tx_ready_i (uart_tx_ready)
    );

    // instructions and data
    sram_bank u_base_ram (
        .clk_i   (clk_i),
        .idx_i   (base_idx),
        .wdata_i (base_wdata),
        .wmask_i (base_wmask),
        .we_i    (base_we),
        .rdata_o (base_rdata)
    );

    // data only
    sram_bank u_ext_ram (
        .clk_i   (clk_i),
        .idx_i   (ext_idx),
        .wdata_i (ext_wdata),
        .wmask_i (ext_wmask),
        .we_i    (ext_we),
        .rdata_o (ext_rdata)
    );

    uart_regs u_uart_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_data_i  (uart_rd_data),
        .wr_data_i  (uart_wr_data),
        .wdata_i    (uart_wdata),
        .rx_byte_i  (rx_byte),
        .rx_valid_i (rx_valid),
        .tx_busy_i  (tx_busy),
        .rx_byte_o  (uart_rx_byte),
        .rx_avail_o (uart_rx_avail),
        .tx_ready_o (uart_tx_ready),
        .tx_start_o (tx_start),
        .tx_byte_o  (tx_byte)
    );

    uart_rx u_uart_rx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rxd_i        (rxd_i),
        .byte_o       (rx_byte),
        .byte_valid_o (rx_valid)
    );

    uart_tx u_uart_tx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (tx_start),
        .byte_i  (tx_byte),
        .txd_o   (txd_o),
        .busy_o  (tx_busy)
    );

endmodule

`default_nettype wire

// File: tb/tb_soc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_soc_mem_top;
    import soc_pkg::*;

    localparam int POLL_LIMIT = 64;     // status polls before giving up
    localparam int EDGE_LIMIT = 40;     // cycles allowed until a start bit

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_FETCH, OP_RX, OP_TX} op_e;

    typedef struct packed {
        op_e               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BE_W-1:0]   be_n;        // active low lanes
        logic [DATA_W-1:0] exp;         // only for reads outside the ram windows
    } entry_t;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic [ADDR_W-1:0] ifu_addr_i;
    logic [DATA_W-1:0] ifu_rdata_o;
    logic              ifu_resp_o;
    logic [ADDR_W-1:0] lsu_addr_i;
    logic [DATA_W-1:0] lsu_wdata_i;
    logic [BE_W-1:0]   lsu_be_n_i;
    logic              lsu_re_i;
    logic              lsu_we_i;
    logic [DATA_W-1:0] lsu_rdata_o;
    logic              lsu_resp_o;
    logic              rxd_i;
    logic              txd_o;

    entry_t            tbl[$];
    logic [DATA_W-1:0] ref_mem [bit [ADDR_W-1:0]];   // reference words keyed by window and index
    int                n_pass;
    int                n_fail;
    int                test_err;

    soc_mem_top u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ifu_addr_i  (ifu_addr_i),
        .ifu_rdata_o (ifu_rdata_o),
        .ifu_resp_o  (ifu_resp_o),
        .lsu_addr_i  (lsu_addr_i),
        .lsu_wdata_i (lsu_wdata_i),
        .lsu_be_n_i  (lsu_be_n_i),
        .lsu_re_i    (lsu_re_i),
        .lsu_we_i    (lsu_we_i),
        .lsu_rdata_o (lsu_rdata_o),
        .lsu_resp_o  (lsu_resp_o),
        .rxd_i       (rxd_i),
        .txd_o       (txd_o)
    );

    always #20 clk_i = ~clk_i;          // 40 ns period

    function automatic logic in_base(input logic [ADDR_W-1:0] a);
        return (a & RAM_WIN_MASK) == BASE_RAM_BASE;
    endfunction

    function automatic logic in_ram(input logic [ADDR_W-1:0] a);
        return in_base(a) || ((a & RAM_WIN_MASK) == EXT_RAM_BASE);
    endfunction

    // window base plus word index above the byte offset
    function automatic bit [ADDR_W-1:0] ram_key(input logic [ADDR_W-1:0] a);
        return (a & RAM_WIN_MASK) | ADDR_W'(a[2 +: RAM_IDX_W]);
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input bit [ADDR_W-1:0] k);
        if (ref_mem.exists(k)) return ref_mem[k];
        return 'x;                      // never written
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] wd,
                                                      input logic [BE_W-1:0]   be_n);
        logic [DATA_W-1:0] r;
        r = old;
        for (int b = 0; b < BE_W; b++) begin
            if (!be_n[b]) r[b*8 +: 8] = wd[b*8 +: 8];   // lane enabled when low
        end
        return r;
    endfunction

    function automatic entry_t make_entry(input op_e op, input logic [ADDR_W-1:0] a,
                                          input logic [DATA_W-1:0] d,
                                          input logic [BE_W-1:0] be_n,
                                          input logic [DATA_W-1:0] exp);
        entry_t e;
        e.op   = op;
        e.addr = a;
        e.data = d;
        e.be_n = be_n;
        e.exp  = exp;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        if (got !== exp) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
            test_err++;
        end
    endtask

    // one strobe cycle sampled mid cycle after the comb paths settle
    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be_n,
                              output logic [DATA_W-1:0] rdata);
        @(posedge clk_i);
        lsu_addr_i  <= addr;
        lsu_wdata_i <= wdata;
        lsu_be_n_i  <= be_n;
        lsu_we_i    <= we;
        lsu_re_i    <= ~we;
        @(negedge clk_i);
        rdata = lsu_rdata_o;
        check_value("lsu_resp_o", 32'd1, 32'(lsu_resp_o));
        check_value("ifu_resp_o", 32'(!in_base(addr)), 32'(ifu_resp_o));  // lost to base access
        @(posedge clk_i);               // write lands on this edge
        lsu_we_i <= 1'b0;
        lsu_re_i <= 1'b0;
    endtask

    task automatic wait_status_bit(input int bit_pos, input logic want);
        logic [DATA_W-1:0] st;
        logic              ok;
        ok = 1'b0;
        for (int i = 0; i < POLL_LIMIT && !ok; i++) begin
            bus_access(1'b0, UART_STAT_ADDR, '0, '1, st);
            ok = (st[bit_pos] === want);
        end
        if (!ok) begin
            $display("timeout: status bit %0d never became %0d", bit_pos, want);
            test_err++;
        end
    endtask

    // start, 8 data bits lsb first, stop
    task automatic send_rx_frame(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_i);
            rxd_i <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_i);
        end
    endtask

    task automatic sample_tx_frame(output logic [7:0] b, output logic stop_bit,
                                   output logic found);
        int waited;
        waited = 0;
        b = '0;
        stop_bit = 1'b0;
        while (txd_o !== 1'b0 && waited < EDGE_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        found = (txd_o === 1'b0);
        if (found) begin
            repeat (CLKS_PER_BIT + HALF_BIT - 1) @(negedge clk_i);   // centre of bit 0
            for (int i = 0; i < 8; i++) begin
                b[i] = txd_o;
                repeat (CLKS_PER_BIT) @(negedge clk_i);
            end
            stop_bit = txd_o;           // now mid stop bit
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp;
        logic [7:0]        got;
        logic              stop_bit;
        logic              found;
        case (e.op)
            OP_WR: begin
                bus_access(1'b1, e.addr, e.data, e.be_n, rd);
                if (in_ram(e.addr)) begin
                    ref_mem[ram_key(e.addr)] = merge_bytes(model_word(ram_key(e.addr)),
                                                           e.data, e.be_n);
                end
            end
            OP_RD: begin
                exp = in_ram(e.addr) ? model_word(ram_key(e.addr)) : e.exp;
                bus_access(1'b0, e.addr, '0, '1, rd);
                check_value("lsu_rdata_o", exp, rd);
            end
            OP_FETCH: begin
                @(posedge clk_i);
                ifu_addr_i <= e.addr;   // held afterwards
                @(negedge clk_i);
                check_value("lsu_resp_o", 32'd0, 32'(lsu_resp_o));   // no strobe this cycle
                check_value("ifu_resp_o", 32'd1, 32'(ifu_resp_o));
                check_value("ifu_rdata_o", model_word(ram_key(e.addr)), ifu_rdata_o);
            end
            OP_RX: begin
                send_rx_frame(e.data[7:0]);
                wait_status_bit(STAT_RX_AVAIL_BIT, 1'b1);
                bus_access(1'b0, UART_DATA_ADDR, '0, '1, rd);
                check_value("lsu_rdata_o", {24'b0, e.data[7:0]}, rd);
                bus_access(1'b0, UART_STAT_ADDR, '0, '1, rd);
                check_value("rx_avail", 32'd0, 32'(rd[STAT_RX_AVAIL_BIT]));   // load cleared it
            end
            default: begin
                fork
                    sample_tx_frame(got, stop_bit, found);
                    begin
                        bus_access(1'b1, UART_DATA_ADDR, e.data, '0, rd);
                        bus_access(1'b0, UART_STAT_ADDR, '0, '1, rd);
                        check_value("tx_ready", 32'd0, 32'(rd[STAT_TX_READY_BIT]));
                    end
                join
                if (!found) begin
                    $display("timeout: no start bit seen on txd_o");
                    test_err++;
                end else begin
                    check_value("txd_o data", 32'(e.data[7:0]), 32'(got));
                    check_value("txd_o stop", 32'd1, 32'(stop_bit));
                end
                wait_status_bit(STAT_TX_READY_BIT, 1'b1);
            end
        endcase
    endtask

    task automatic report_test(input int idx, input string what);
        if (test_err == 0) begin
            n_pass++;
            $display("test %0d %s ok", idx, what);
        end else begin
            n_fail++;
            $display("test %0d %s FAILED with %0d errors", idx, what, test_err);
        end
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] r0;
        logic [DATA_W-1:0] r1;
        logic [DATA_W-1:0] r2;
        logic [DATA_W-1:0] r3;
        r0 = $urandom();
        r1 = $urandom();
        r2 = $urandom();
        r3 = $urandom();
        tbl.push_back(make_entry(OP_RD, UART_STAT_ADDR, '0, '1, 32'h1));   // tx ready only
        // ext ram byte lanes
        tbl.push_back(make_entry(OP_WR, 32'h8040_0010, 32'h1122_3344, 4'b0000, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8040_0010, 32'haabb_ccdd, 4'b1010, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8040_0010, '0, '1, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8040_0014, 32'hdead_beef, 4'b0000, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8040_0014, 32'h0000_5a00, 4'b1101, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8040_0014, '0, '1, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8040_0010, r0, 4'b0111, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8040_0010, '0, '1, '0));
        // base ram seen from both ports
        tbl.push_back(make_entry(OP_WR, 32'h8000_0020, 32'hcafe_f00d, 4'b0000, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8000_0020, '0, '1, '0));
        tbl.push_back(make_entry(OP_FETCH, 32'h8000_0020, '0, '1, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8000_0024, r1, 4'b0000, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8000_0024, r2, 4'b1100, '0));
        tbl.push_back(make_entry(OP_FETCH, 32'h8000_0024, '0, '1, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8040_0014, '0, '1, '0));
        // serial
        tbl.push_back(make_entry(OP_RX, UART_DATA_ADDR, {24'b0, r3[7:0]}, '1, '0));
        tbl.push_back(make_entry(OP_TX, UART_DATA_ADDR, {24'b0, r3[15:8]}, '0, '0));
        // unmapped address at word index 16 of both banks
        tbl.push_back(make_entry(OP_WR, 32'h8000_0040, 32'h0bad_0001, 4'b0000, '0));
        tbl.push_back(make_entry(OP_WR, 32'h8040_0040, 32'h0bad_0002, 4'b0000, '0));
        tbl.push_back(make_entry(OP_WR, 32'h1000_0040, 32'hffff_ffff, 4'b0000, '0));
        tbl.push_back(make_entry(OP_RD, 32'h1000_0040, '0, '1, 32'h0));
        tbl.push_back(make_entry(OP_RD, 32'h8000_0040, '0, '1, '0));
        tbl.push_back(make_entry(OP_RD, 32'h8040_0040, '0, '1, '0));
    endtask

    initial begin
        void'($urandom(32'h1a9b));
        rst_i       <= 1'b1;
        ifu_addr_i  <= BASE_RAM_BASE;
        lsu_addr_i  <= '0;
        lsu_wdata_i <= '0;
        lsu_be_n_i  <= '1;
        lsu_re_i    <= 1'b0;
        lsu_we_i    <= 1'b0;
        rxd_i       <= 1'b1;            // idle line
        n_pass = 0;
        n_fail = 0;
        build_table();
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        test_err = 0;
        check_value("txd_o", 32'd1, 32'(txd_o));
        check_value("ifu_resp_o", 32'd1, 32'(ifu_resp_o));
        report_test(0, "reset");
        for (int i = 0; i < tbl.size(); i++) begin
            test_err = 0;
            apply_entry(tbl[i]);
            report_test(i + 1, tbl[i].op.name());
        end
        $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/soc_pkg.sv
logic/sram_bank.sv
logic/mem_bridge.sv
logic/uart_regs.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/soc_mem_top.sv
tb/tb_soc_mem_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps -f project.f \
    --top-module tb_soc_mem_top -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1
